// ==== source/ncpu32k_params.svh ====
// Width macros for the execute unit; NCPU_SHW must equal log2 of NCPU_DW, no check enforces it.
`ifndef NCPU32K_PARAMS_SVH
`define NCPU32K_PARAMS_SVH

// ==================================================
// Datapath widths
// ==================================================

// Data word width in bits.
// The datapath is written for 16, 32 or 64.
`define NCPU_DW 32

// Shift-amount width in bits.
// Base-2 logarithm of the word width.
// Also sizes the multiplier step counter.
`define NCPU_SHW 5

// ==================================================
// Derived values
// ==================================================

// Index of the sign bit of a word.
`define NCPU_MSB (`NCPU_DW - 1)

// Number of shift-add steps in one multiply.
// One step per multiplier bit.
`define NCPU_MUL_STEPS `NCPU_DW

`endif

// ==== source/ncpu32k_pkg.sv ====
// Shared types of the execute unit; opcodes 9 to 15 are undefined and return a zero result.
`default_nettype none

`include "ncpu32k_params.svh"

package ncpu32k_pkg;

   // ==================================================
   // Width types
   // ==================================================

   // One data word.
   typedef logic [`NCPU_DW-1:0] word_t;

   // Shift amount, low bits of operand 2.
   typedef logic [`NCPU_SHW-1:0] shamt_t;

   // ==================================================
   // Opcodes
   // ==================================================

   // Execute unit opcode as issued from outside.
   typedef enum logic [3:0] {
      OPC_ADD = 4'd0,
      OPC_SUB = 4'd1,
      OPC_AND = 4'd2,
      OPC_OR  = 4'd3,
      OPC_XOR = 4'd4,
      OPC_SHL = 4'd5,
      OPC_SHR = 4'd6,
      OPC_SAR = 4'd7,
      OPC_MUL = 4'd8
   } ieu_opc_t;

   // Logic unit sub-operation.
   typedef enum logic [2:0] {
      LU_AND = 3'd0,
      LU_OR  = 3'd1,
      LU_XOR = 3'd2,
      LU_SHL = 3'd3,
      LU_SHR = 3'd4,
      LU_SAR = 3'd5
   } lu_op_t;

   // ==================================================
   // Request and result
   // ==================================================

   typedef struct packed {
      ieu_opc_t opc;
      word_t    operand_1;
      word_t    operand_2;
   } ieu_req_t;

   // Flags are zero for anything but add and subtract.
   typedef struct packed {
      word_t data;
      logic  carry;
      logic  overflow;
   } ieu_result_t;

   // Control FSM.
   typedef enum logic {
      ST_IDLE = 1'b0,
      ST_MUL  = 1'b1
   } ctrl_state_t;

endpackage

`default_nettype wire

// ==== source/ncpu32k_ie_au.sv ====
// Combinational adder and subtractor; on subtract a carry of 1 means no borrow occurred.
`timescale 1ns/100ps
`default_nettype none

`include "ncpu32k_params.svh"

module ncpu32k_ie_au
   import ncpu32k_pkg::*;
(
   input  word_t operand_1,
   input  word_t operand_2,
   input  logic  add_sub,
   output word_t sum,
   output logic  carry,
   output logic  overflow
);

   // ==================================================
   // Operand preparation
   // ==================================================

   // Second addend, inverted for subtract.
   word_t operand_2_com;
   // Carry into bit 0.
   logic  carry_in;
   // Sign bits of both addends and of the sum.
   logic  sign_1;
   logic  sign_2;
   logic  sign_sum;

   // Subtract is op1 + ~op2 + 1.
   // The +1 comes in through the carry input.
   assign carry_in      = add_sub;
   assign operand_2_com = add_sub ? ~operand_2 : operand_2;

   // ==================================================
   // Single adder
   // ==================================================

   // One extra bit on top catches the carry out.
   assign {carry, sum} = {1'b0, operand_1} + {1'b0, operand_2_com}
                       + {{`NCPU_DW{1'b0}}, carry_in};

   // ==================================================
   // Signed overflow
   // ==================================================

   assign sign_1   = operand_1[`NCPU_MSB];
   assign sign_2   = operand_2_com[`NCPU_MSB];
   assign sign_sum = sum[`NCPU_MSB];

   // Same-signed addends giving a sum of the other sign.
   // Uses the complemented operand, so subtract is covered too.
   assign overflow = (sign_1 == sign_2) & (sign_1 ^ sign_sum);

endmodule

`default_nettype wire

// ==== source/ncpu32k_ie_lu.sv ====
// Combinational logic and shift unit; shifts use only the low NCPU_SHW bits of operand 2.
`timescale 1ns/100ps
`default_nettype none

`include "ncpu32k_params.svh"

module ncpu32k_ie_lu
   import ncpu32k_pkg::*;
(
   input  word_t  operand_1,
   input  word_t  operand_2,
   input  lu_op_t lu_op,
   output word_t  result
);

   // Shift amount from operand 2.
   shamt_t shamt;
   // Input to the right shifter, bit reversed for SHL.
   word_t  shift_in;
   // Bit shifted in from the top.
   logic   fill;
   // One entry per barrel stage, stage 0 is the input.
   word_t  stage [0:`NCPU_SHW];
   // Final shifter output, in normal bit order.
   word_t  shift_out;

   // Mirror a word end to end.
   function automatic word_t reverse(input word_t w);
      word_t r;
      for (int i = 0; i < `NCPU_DW; i++) begin
         r[i] = w[`NCPU_MSB-i];
      end
      return r;
   endfunction

   // ==================================================
   // Barrel shifter
   // ==================================================

   assign shamt = operand_2[`NCPU_SHW-1:0];

   // A left shift is a right shift of the mirrored word.
   assign shift_in = (lu_op == LU_SHL) ? reverse(operand_1) : operand_1;

   // Only SAR fills with the sign bit.
   assign fill = (lu_op == LU_SAR) & operand_1[`NCPU_MSB];

   assign stage[0] = shift_in;

   // Stage i shifts by 2**i when shamt bit i is set.
   for (genvar i = 0; i < `NCPU_SHW; i++) begin : g_stage
      localparam int step = 1 << i;
      assign stage[i+1] = shamt[i] ? {{step{fill}}, stage[i][`NCPU_MSB:step]}
                                   : stage[i];
   end

   // Undo the mirror for SHL.
   assign shift_out = (lu_op == LU_SHL) ? reverse(stage[`NCPU_SHW]) : stage[`NCPU_SHW];

   // ==================================================
   // Output select
   // ==================================================

   always_comb begin
      case (lu_op)
         LU_AND:  result = operand_1 & operand_2;
         LU_OR:   result = operand_1 | operand_2;
         LU_XOR:  result = operand_1 ^ operand_2;
         LU_SHL,
         LU_SHR,
         LU_SAR:  result = shift_out;
         default: result = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== source/ncpu32k_ie_mul.sv ====
// Shift-add multiplier, low product word only; mul_done comes NCPU_DW cycles after mul_start.
`timescale 1ns/100ps
`default_nettype none

`include "ncpu32k_params.svh"

module ncpu32k_ie_mul
   import ncpu32k_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   input  logic  mul_start,
   input  word_t multiplicand,
   input  word_t multiplier,
   output word_t product,
   output logic  mul_done
);

   // ==================================================
   // State
   // ==================================================

   // Run in progress.
   logic   running;
   // Index of the step done on the next edge.
   shamt_t step_cnt;
   // Multiplicand, moved left one bit per step.
   word_t  mcand_q;
   // Multiplier, moved right so bit 0 is the current bit.
   word_t  mplier_q;
   // Partial product, low word only.
   word_t  acc_q;

   // Control state, cleared on reset.
   always_ff @(posedge clk) begin
      if (rst) begin
         running  <= 1'b0;
         step_cnt <= '0;
         mul_done <= 1'b0;
      end else begin
         mul_done <= 1'b0;
         if (mul_start) begin
            // Step 0 is done on the start edge.
            running  <= 1'b1;
            step_cnt <= shamt_t'(1);
         end else if (running) begin
            if (step_cnt == shamt_t'(`NCPU_MUL_STEPS - 1)) begin
               // Last step, done shows up next cycle.
               running  <= 1'b0;
               mul_done <= 1'b1;
            end else begin
               step_cnt <= step_cnt + shamt_t'(1);
            end
         end
      end
   end

   // ==================================================
   // Datapath
   // ==================================================

   // Payload registers, no reset.
   always_ff @(posedge clk) begin
      if (mul_start) begin
         // Load and do step 0 in one go.
         acc_q    <= multiplier[0] ? multiplicand : '0;
         mcand_q  <= multiplicand << 1;
         mplier_q <= multiplier >> 1;
      end else if (running) begin
         if (mplier_q[0]) begin
            acc_q <= acc_q + mcand_q;
         end
         mcand_q  <= mcand_q << 1;
         mplier_q <= mplier_q >> 1;
      end
   end

   // Final once mul_done is high.
   assign product = acc_q;

   // ==================================================
   // Checks
   // ==================================================

   // A new start would throw away the run in progress.
   a_no_start_while_running: assert property (
      @(posedge clk) disable iff (rst) mul_start |-> !running
   );

endmodule

`default_nettype wire

// ==== source/ncpu32k_ie_ctrl.sv ====
// Execute control; issue only while busy is low, and the result is held only until the next one.
`timescale 1ns/100ps
`default_nettype none

module ncpu32k_ie_ctrl
   import ncpu32k_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        issue,
   input  ieu_req_t    req,
   output logic        busy,
   output logic        result_valid,
   output ieu_result_t result,
   output logic        add_sub,
   output lu_op_t      lu_op,
   output logic        mul_start,
   input  word_t       sum,
   input  logic        carry,
   input  logic        overflow,
   input  word_t       lu_result,
   input  word_t       product,
   input  logic        mul_done
);

   ctrl_state_t state;
   ieu_opc_t    opc;
   // Request is a multiply.
   logic        is_mul;
   // Single-cycle result of the issued request.
   ieu_result_t sel_result;

   // ==================================================
   // Decode
   // ==================================================

   assign opc    = req.opc;
   assign is_mul = (opc == OPC_MUL);

   // Adder runs as subtractor only for SUB.
   assign add_sub = (opc == OPC_SUB);

   // Operands go straight from the request, so start must be in the issue cycle.
   assign mul_start = issue & is_mul;

   assign busy = (state == ST_MUL);

   always_comb begin
      case (opc)
         OPC_OR:  lu_op = LU_OR;
         OPC_XOR: lu_op = LU_XOR;
         OPC_SHL: lu_op = LU_SHL;
         OPC_SHR: lu_op = LU_SHR;
         OPC_SAR: lu_op = LU_SAR;
         default: lu_op = LU_AND;
      endcase
   end

   // Result select for everything but MUL.
   // Flags come through only for ADD and SUB.
   always_comb begin
      sel_result = '0;
      case (opc)
         OPC_ADD, OPC_SUB: begin
            sel_result.data     = sum;
            sel_result.carry    = carry;
            sel_result.overflow = overflow;
         end
         OPC_AND, OPC_OR, OPC_XOR, OPC_SHL, OPC_SHR, OPC_SAR: begin
            sel_result.data = lu_result;
         end
         default: ;
      endcase
   end

   // ==================================================
   // FSM and result register
   // ==================================================

   always_ff @(posedge clk) begin
      if (rst) begin
         state        <= ST_IDLE;
         result_valid <= 1'b0;
         result       <= '0;
      end else begin
         result_valid <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (issue) begin
                  if (is_mul) begin
                     state <= ST_MUL;
                  end else begin
                     result       <= sel_result;
                     result_valid <= 1'b1;
                  end
               end
            end
            ST_MUL: begin
               // Product is ready, register it and go back.
               if (mul_done) begin
                  result       <= '{data: product, carry: 1'b0, overflow: 1'b0};
                  result_valid <= 1'b1;
                  state        <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // ==================================================
   // Checks
   // ==================================================

   a_no_issue_while_busy: assert property (
      @(posedge clk) disable iff (rst) issue |-> !busy
   );

   // One result per request.
   a_valid_single_pulse: assert property (
      @(posedge clk) disable iff (rst) result_valid |=> !result_valid
   );

   a_done_only_in_mul: assert property (
      @(posedge clk) disable iff (rst) mul_done |-> (state == ST_MUL)
   );

endmodule

`default_nettype wire

// ==== source/ncpu32k_ieu.sv ====
// Execute unit top; no back-pressure, so the caller must take result_valid when it pulses.
`timescale 1ns/100ps
`default_nettype none

module ncpu32k_ieu
   import ncpu32k_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        issue,
   input  ieu_req_t    req,
   output logic        busy,
   output logic        result_valid,
   output ieu_result_t result
);

   // Control to datapath.
   logic   add_sub;
   lu_op_t lu_op;
   logic   mul_start;
   // Datapath to control.
   word_t  sum;
   logic   carry;
   logic   overflow;
   word_t  lu_result;
   word_t  product;
   logic   mul_done;

   // ==================================================
   // Control
   // ==================================================

   ncpu32k_ie_ctrl ctrl_i (
      .clk          (clk),
      .rst          (rst),
      .issue        (issue),
      .req          (req),
      .busy         (busy),
      .result_valid (result_valid),
      .result       (result),
      .add_sub      (add_sub),
      .lu_op        (lu_op),
      .mul_start    (mul_start),
      .sum          (sum),
      .carry        (carry),
      .overflow     (overflow),
      .lu_result    (lu_result),
      .product      (product),
      .mul_done     (mul_done)
   );

   // ==================================================
   // Datapath
   // ==================================================

   // Operands come straight from the request.
   ncpu32k_ie_au au_i (
      .operand_1 (req.operand_1),
      .operand_2 (req.operand_2),
      .add_sub   (add_sub),
      .sum       (sum),
      .carry     (carry),
      .overflow  (overflow)
   );

   ncpu32k_ie_lu lu_i (
      .operand_1 (req.operand_1),
      .operand_2 (req.operand_2),
      .lu_op     (lu_op),
      .result    (lu_result)
   );

   // Latches operands on mul_start.
   ncpu32k_ie_mul mul_i (
      .clk          (clk),
      .rst          (rst),
      .mul_start    (mul_start),
      .multiplicand (req.operand_1),
      .multiplier   (req.operand_2),
      .product      (product),
      .mul_done     (mul_done)
   );

endmodule

`default_nettype wire

// ==== verification/ncpu32k_ieu_tb.sv ====
// Directed and random tests of the execute unit; MUL latency is taken from result_valid only.
`timescale 1ns/100ps
`default_nettype none

`include "ncpu32k_params.svh"

module ncpu32k_ieu_tb
   import ncpu32k_pkg::*;
();

   // ==================================================
   // DUT, clock and globals
   // ==================================================

   // Upper bound for any wait on result_valid.
   localparam int TIMEOUT_CYCLES = 4 * `NCPU_DW + 16;

   logic        clk;
   logic        rst;
   logic        issue;
   ieu_req_t    req;
   logic        busy;
   logic        result_valid;
   ieu_result_t result;
   // LCG state.
   logic [31:0] lcg_state;

   ncpu32k_ieu ncpu32k_ieu_i (
      .clk          (clk),
      .rst          (rst),
      .issue        (issue),
      .req          (req),
      .busy         (busy),
      .result_valid (result_valid),
      .result       (result)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   // ==================================================
   // Helpers
   // ==================================================

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Two draws, so 64-bit words are fully covered.
   function automatic word_t rand_word();
      logic [63:0] bits;
      bits[63:32] = lcg_next();
      bits[31:0]  = lcg_next();
      return word_t'(bits);
   endfunction

   // Expected result straight from the arithmetic rules.
   function automatic ieu_result_t expected_result(input ieu_req_t r);
      ieu_result_t       e;
      word_t             a;
      word_t             b;
      logic [`NCPU_DW:0] wide;
      shamt_t            sh;
      e  = '0;
      a  = r.operand_1;
      b  = r.operand_2;
      sh = shamt_t'(b);
      case (r.opc)
         OPC_ADD: begin
            wide       = {1'b0, a} + {1'b0, b};
            e.data     = wide[`NCPU_DW-1:0];
            e.carry    = wide[`NCPU_DW];
            e.overflow = (a[`NCPU_MSB] == b[`NCPU_MSB]) && (e.data[`NCPU_MSB] != a[`NCPU_MSB]);
         end
         OPC_SUB: begin
            e.data     = a - b;
            // No borrow exactly when a >= b as unsigned.
            e.carry    = (a >= b);
            e.overflow = (a[`NCPU_MSB] != b[`NCPU_MSB]) && (e.data[`NCPU_MSB] != a[`NCPU_MSB]);
         end
         OPC_AND: e.data = a & b;
         OPC_OR:  e.data = a | b;
         OPC_XOR: e.data = a ^ b;
         OPC_SHL: e.data = a << sh;
         OPC_SHR: e.data = a >> sh;
         OPC_SAR: e.data = word_t'($signed(a) >>> sh);
         OPC_MUL: e.data = word_t'(a * b);
         default: e = '0;
      endcase
      return e;
   endfunction

   task automatic stop_run(input string why);
      if (why != "") begin
         $display("%s", why);
      end
      $display("Simulation FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic compare_word(input string what, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("ERR @%0t ns: %s data %h, expected %h", $time, what, got, exp);
         stop_run("");
      end
   endtask

   task automatic compare_flags(input string what, input ieu_result_t got,
                                input ieu_result_t exp);
      if (got.carry !== exp.carry || got.overflow !== exp.overflow) begin
         $display("ERR @%0t ns: %s carry/overflow %b%b, expected %b%b", $time, what,
                  got.carry, got.overflow, exp.carry, exp.overflow);
         stop_run("");
      end
   endtask

   // One issue pulse, then wait for result_valid.
   // Values seen at an edge belong to the cycle before it.
   task automatic run_op(input ieu_req_t r, output ieu_result_t got, output int lat);
      int n;
      @(posedge clk);
      issue <= 1'b1;
      req   <= r;
      @(posedge clk);
      issue <= 1'b0;
      // Cycle 0 is the issue cycle itself.
      n = 0;
      while (!result_valid) begin
         if (busy !== (n > 0 && r.opc == OPC_MUL)) begin
            stop_run($sformatf("ERR @%0t ns: busy is %b in cycle %0d after issue of %s",
                               $time, busy, n, r.opc.name()));
         end
         if (n >= TIMEOUT_CYCLES) begin
            stop_run("Timeout: result_valid never came after an issue.");
         end
         @(posedge clk);
         n++;
      end
      if (busy !== 1'b0) begin
         stop_run($sformatf("ERR @%0t ns: busy is still high in the result_valid cycle",
                            $time));
      end
      got = result;
      lat = n;
   endtask

   task automatic check_op(input ieu_opc_t opc, input word_t a, input word_t b);
      ieu_req_t    r;
      ieu_result_t got;
      ieu_result_t exp;
      int          lat;
      string       what;
      r    = '{opc: opc, operand_1: a, operand_2: b};
      exp  = expected_result(r);
      what = $sformatf("%s %h %h", opc.name(), a, b);
      run_op(r, got, lat);
      if (lat == 0 || (opc != OPC_MUL && lat != 1)) begin
         stop_run($sformatf("ERR @%0t ns: %s gave result_valid %0d cycles after issue",
                            $time, what, lat));
      end
      compare_word(what, got.data, exp.data);
      compare_flags(what, got, exp);
   endtask

   // ==================================================
   // Tests
   // ==================================================

   task automatic reset_state();
      if (busy !== 1'b0 || result_valid !== 1'b0) begin
         stop_run($sformatf("ERR @%0t ns: busy or result_valid is high after reset", $time));
      end
      // Result register comes out of reset cleared.
      compare_word("result after reset", result.data, '0);
      compare_flags("result after reset", result, '0);
      check_op(OPC_ADD, word_t'(5), word_t'(7));
   endtask

   task automatic add_sub_corners();
      word_t ones;
      word_t maxp;
      word_t minn;
      ones = '1;
      maxp = ones >> 1;
      minn = ~maxp;
      check_op(OPC_ADD, '0, '0);
      check_op(OPC_ADD, ones, word_t'(1));
      check_op(OPC_ADD, maxp, word_t'(1));
      check_op(OPC_ADD, minn, ones);
      check_op(OPC_SUB, '0, '0);
      check_op(OPC_SUB, '0, word_t'(1));
      check_op(OPC_SUB, minn, word_t'(1));
      check_op(OPC_SUB, maxp, ones);
   endtask

   task automatic logic_patterns();
      word_t p1;
      word_t p2;
      p1 = word_t'({2{32'hf0f0_a5a5}});
      p2 = word_t'({2{32'h0ff0_5a3c}});
      check_op(OPC_AND, p1, p2);
      check_op(OPC_OR,  p1, p2);
      check_op(OPC_XOR, p1, p2);
      check_op(OPC_XOR, p1, '1);
   endtask

   task automatic shift_amounts();
      word_t    neg_val;
      word_t    amounts [4];
      ieu_opc_t ops [3];
      neg_val    = ~(~word_t'(0) >> 1) | word_t'({2{32'h5a5a_3c3c}});
      // Last amount has its upper bits set.
      // Only the low 3 may count.
      amounts[0] = '0;
      amounts[1] = word_t'(1);
      amounts[2] = word_t'(`NCPU_DW - 1);
      amounts[3] = (~word_t'(0) << `NCPU_SHW) | word_t'(3);
      ops[0]     = OPC_SHL;
      ops[1]     = OPC_SHR;
      ops[2]     = OPC_SAR;
      foreach (ops[i]) begin
         foreach (amounts[j]) begin
            check_op(ops[i], neg_val, amounts[j]);
         end
      end
      check_op(OPC_SAR, word_t'(32'h1234_5678), word_t'(4));
   endtask

   task automatic multiply_cases();
      check_op(OPC_MUL, word_t'(3), word_t'(5));
      check_op(OPC_MUL, '1, '1);
      check_op(OPC_MUL, '1, word_t'(7));
      check_op(OPC_MUL, ~(~word_t'(0) >> 1), word_t'(2));
      check_op(OPC_MUL, word_t'(12345), word_t'(6789));
      // Non-multiply right after a multiply.
      check_op(OPC_SUB, word_t'(100), word_t'(42));
   endtask

   task automatic random_mix();
      ieu_opc_t opc;
      word_t    a;
      word_t    b;
      for (int i = 0; i < 200; i++) begin
         opc = ieu_opc_t'(4'(lcg_next() % 32'd9));
         a   = rand_word();
         b   = rand_word();
         check_op(opc, a, b);
      end
   endtask

   // ==================================================
   // Sequence
   // ==================================================

   initial begin
      lcg_state = 32'h93fa_7cca;
      rst       = 1'b1;
      issue     = 1'b0;
      req       = '0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      reset_state();
      add_sub_corners();
      logic_patterns();
      shift_amounts();
      multiply_cases();
      random_mix();
      // Any failed check has already stopped the run.
      $display("Simulation PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+source
source/ncpu32k_pkg.sv
source/ncpu32k_ie_au.sv
source/ncpu32k_ie_lu.sv
source/ncpu32k_ie_mul.sv
source/ncpu32k_ie_ctrl.sv
source/ncpu32k_ieu.sv
verification/ncpu32k_ieu_tb.sv

// ==== Makefile ====
# Verilator build and run of the execute unit testbench.
VERILATOR ?= verilator
TOP       ?= ncpu32k_ieu_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard source/*.sv source/*.svh verification/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log decides the outcome, so a fatal exit of the binary is not trusted alone.
run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "Pass message not found in $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
